// File: all.f
verilog/l1_cache_pkg.sv
verilog/sram.sv
verilog/l1_cache_controller.sv
verilog/l1_cache.sv
dv/ext_mem_model.sv
dv/tb_l1_cache.sv

// File: Bender.yml
package:
  name: l1_cache

sources:
  - verilog/l1_cache_pkg.sv
  - verilog/sram.sv
  - verilog/l1_cache_controller.sv
  - verilog/l1_cache.sv
  - target: test
    files:
      - dv/ext_mem_model.sv
      - dv/tb_l1_cache.sv

// File: dv/tb_l1_cache.sv
`default_nettype none

module tb_l1_cache;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rst_n;
	logic cs;
	l1_cache_pkg::cpu_req_t req;
	logic [31:0] rdata;
	logic stall;
	logic ext_req;
	l1_cache_pkg::mem_req_t ext_mreq;
	logic ext_ack;
	logic [l1_cache_pkg::BLOCK_W-1:0] ext_rdata;

	logic [31:0] ref_mem [0:1023]; // indexed by addr[11:2]
	logic [31:0] rand_q;
	int wb_count;
	logic [31:0] last_wb_addr;

	always #2 clk = ~clk;

	l1_cache u_dut (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.cs_i        (cs),
		.req_i       (req),
		.ext_ack_i   (ext_ack),
		.ext_rdata_i (ext_rdata),
		.rdata_o     (rdata),
		.stall_o     (stall),
		.ext_req_o   (ext_req),
		.ext_mreq_o  (ext_mreq)
	);

	ext_mem_model u_mem (
		.clk_i   (clk),
		.rst_n_i (rst_n),
		.req_i   (ext_req),
		.mreq_i  (ext_mreq),
		.ack_o   (ext_ack),
		.rdata_o (ext_rdata)
	);

	// writeback handshakes seen on the ports
	// req and ack overlap for one cycle
	always @(negedge clk) begin
		if (rst_n && ext_req && ext_ack && ext_mreq.we) begin
			wb_count <= wb_count + 1;
			last_wb_addr <= ext_mreq.addr;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// t lands in the low two tag bits
	function automatic logic [31:0] make_addr(input logic [1:0] t, input logic [4:0] idx,
			input logic [2:0] w);
		logic [21:0] tag;
		tag = 22'h2b5c4 + {20'd0, t};
		return {tag, idx, w, 2'b00};
	endfunction

	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return ({addr[31:5], 5'd0} ^ 32'h5a5a0000) + {27'd0, addr[4:2], 2'b00};
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_values(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			stop_with_failure($sformatf("mismatch %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// one processor access
	// cycles counts edges until stall drops
	task automatic cpu_access(input string name, input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] got, output int cycles);
		int n;
		bit done;
		@(posedge clk);
		cs <= 1'b1;
		req.addr <= addr;
		req.wdata <= wdata;
		req.we <= we;
		n = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (!stall) begin
				done = 1'b1;
			end else begin
				n++;
				if (n > 500) begin
					stop_with_failure($sformatf("%s: stall_o never dropped for address %h",
						name, addr));
				end
			end
		end
		got = rdata;
		cycles = n;
		@(posedge clk);
		cs <= 1'b0;
	endtask

	task automatic read_word(input string name, input logic [31:0] addr);
		logic [31:0] got;
		int cycles;
		cpu_access(name, 1'b0, addr, 32'd0, got, cycles);
		compare_values(name, ref_mem[addr[11:2]], got);
	endtask

	task automatic write_word(input string name, input logic [31:0] addr,
			input logic [31:0] data, output int cycles);
		logic [31:0] got;
		cpu_access(name, 1'b1, addr, data, got, cycles);
		ref_mem[addr[11:2]] = data;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_state();
		@(negedge clk);
		compare_values("reset_state ext_req", 32'd0, {31'd0, ext_req});
		compare_values("reset_state stall", 32'd0, {31'd0, stall});
	endtask

	task automatic test_read_miss_then_hit();
		logic [31:0] addr;
		logic [31:0] got;
		int cycles;
		addr = make_addr(2'd0, 5'd3, 3'd5);
		cpu_access("read_miss_then_hit", 1'b0, addr, 32'd0, got, cycles);
		compare_values("read_miss_then_hit miss data", init_word(addr), got);
		compare_values("read_miss_then_hit miss slow", 32'd1, {31'd0, cycles > 1});
		cpu_access("read_miss_then_hit", 1'b0, addr, 32'd0, got, cycles);
		compare_values("read_miss_then_hit hit data", init_word(addr), got);
		compare_values("read_miss_then_hit hit cycles", 32'd1, cycles);
	endtask

	task automatic test_write_hit_readback();
		logic [31:0] addr;
		int cycles;
		addr = make_addr(2'd1, 5'd4, 3'd2);
		read_word("write_hit_readback fill", addr);
		write_word("write_hit_readback", addr, 32'hcafe0001, cycles);
		compare_values("write_hit_readback write cycles", 32'd1, cycles);
		for (int w = 0; w < 8; w++) begin
			read_word("write_hit_readback block", make_addr(2'd1, 5'd4, w[2:0]));
		end
	endtask

	task automatic test_dirty_eviction();
		logic [31:0] a;
		logic [31:0] b;
		int cycles;
		int wb_before;
		a = make_addr(2'd2, 5'd7, 3'd1);
		b = make_addr(2'd3, 5'd7, 3'd6); // same line with another tag
		write_word("dirty_eviction write", a, 32'h0badf00d, cycles);
		wb_before = wb_count;
		read_word("dirty_eviction read b", b);
		compare_values("dirty_eviction wb count", wb_before + 1, wb_count);
		compare_values("dirty_eviction wb addr", {a[31:5], 5'd0}, last_wb_addr);
		compare_values("dirty_eviction memory word", 32'h0badf00d, u_mem.stored_word(a));
		read_word("dirty_eviction reread a", a);
	endtask

	task automatic test_random_traffic();
		logic [31:0] addr;
		int cycles;
		for (int i = 0; i < 200; i++) begin
			rand_q = xorshift32(rand_q);
			addr = make_addr(rand_q[1:0], {3'b010, rand_q[3:2]}, rand_q[6:4]); // lines 8..11
			if (rand_q[7]) begin
				rand_q = xorshift32(rand_q);
				write_word("random_traffic write", addr, rand_q, cycles);
			end else begin
				read_word("random_traffic read", addr);
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cs = 1'b0;
		req = '0;
		wb_count = 0;
		last_wb_addr = '0;
		rand_q = 32'he9b0a169;
		for (int i = 0; i < 1024; i++) begin
			ref_mem[i] = init_word(make_addr(i[9:8], i[7:3], i[2:0]));
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_state();
		test_read_miss_then_hit();
		test_write_hit_readback();
		test_dirty_eviction();
		test_random_traffic();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/ext_mem_model.sv
`default_nettype none

// block memory on the far side of the four-phase handshake
module ext_mem_model (
	input  wire                               clk_i,
	input  wire                               rst_n_i,
	input  wire                               req_i,
	input  wire  l1_cache_pkg::mem_req_t      mreq_i,
	output logic                              ack_o,
	output logic [l1_cache_pkg::BLOCK_W-1:0]  rdata_o
);

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {
		M_IDLE,
		M_WAIT, // random delay before ack
		M_ACK   // ack high until req drops
	} mem_phase_t;

	mem_phase_t phase;
	logic [1:0] delay_cnt;
	logic [31:0] rand_q;
	logic [l1_cache_pkg::BLOCK_W-1:0] blocks [0:127]; // slot = addr[11:5]
	logic [127:0] written;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// untouched blocks hold (block address xor 5a5a0000) + 4w
	function automatic logic [l1_cache_pkg::BLOCK_W-1:0] init_block(input logic [31:0] addr);
		logic [l1_cache_pkg::BLOCK_W-1:0] blk;
		logic [31:0] base;
		base = {addr[31:5], 5'd0} ^ 32'h5a5a0000;
		for (int w = 0; w < 8; w++) begin
			blk[32*w +: 32] = base + 32'(w * 4);
		end
		return blk;
	endfunction

	function automatic logic [l1_cache_pkg::BLOCK_W-1:0] block_at(input logic [31:0] addr);
		if (written[addr[11:5]]) begin
			return blocks[addr[11:5]];
		end
		return init_block(addr);
	endfunction

	// word as memory holds it now, for the testbench
	function automatic logic [31:0] stored_word(input logic [31:0] addr);
		logic [l1_cache_pkg::BLOCK_W-1:0] blk;
		blk = block_at(addr);
		return blk[32*addr[4:2] +: 32];
	endfunction

	initial begin
		ack_o = 1'b0;
		rdata_o = '0;
	end

	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			phase <= M_IDLE;
			ack_o <= 1'b0;
			delay_cnt <= 2'd0;
			written <= '0;
			rand_q <= 32'he9b0a169;
		end else begin
			case (phase)
				M_IDLE: begin
					if (req_i) begin
						rand_q <= xorshift32(rand_q);
						delay_cnt <= rand_q[1:0]; // zero to three cycles
						phase <= M_WAIT;
					end
				end
				M_WAIT: begin
					if (delay_cnt == 2'd0) begin
						if (mreq_i.we) begin
							blocks[mreq_i.addr[11:5]] <= mreq_i.wdata;
							written[mreq_i.addr[11:5]] <= 1'b1;
						end else begin
							rdata_o <= block_at(mreq_i.addr);
						end
						ack_o <= 1'b1;
						phase <= M_ACK;
					end else begin
						delay_cnt <= delay_cnt - 2'd1;
					end
				end
				default: begin
					if (!req_i) begin
						ack_o <= 1'b0; // phase four
						phase <= M_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/l1_cache.sv
`default_nettype none

module l1_cache (
	input  wire                                   clk,
	input  wire                                   rst_n_i,
	input  wire                                   cs_i,
	input  wire  l1_cache_pkg::cpu_req_t          req_i,
	input  wire                                   ext_ack_i,
	input  wire  [l1_cache_pkg::BLOCK_W-1:0]      ext_rdata_i,
	output logic [l1_cache_pkg::DATA_W-1:0]       rdata_o,
	output logic                                  stall_o,
	output logic                                  ext_req_o,
	output l1_cache_pkg::mem_req_t                ext_mreq_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address split
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [l1_cache_pkg::TAG_W-1:0]      req_tag;
	logic [l1_cache_pkg::INDEX_W-1:0]    req_index;
	logic [l1_cache_pkg::WORD_SEL_W-1:0] req_word;

	assign req_tag   = req_i.addr[l1_cache_pkg::ADDR_W-1 -: l1_cache_pkg::TAG_W];
	assign req_index = req_i.addr[l1_cache_pkg::OFFSET_W +: l1_cache_pkg::INDEX_W];
	assign req_word  = req_i.addr[l1_cache_pkg::OFFSET_W - l1_cache_pkg::WORD_SEL_W +:
	                              l1_cache_pkg::WORD_SEL_W]; // bits 4..2

	// controller handshake
	logic sram_cs;
	logic line_we;
	logic fill;
	logic victim;
	logic valid_set;
	logic ext_we;
	logic hit;
	logic dirty;

	// store ports
	l1_cache_pkg::tag_entry_t             tag_rd;
	l1_cache_pkg::tag_entry_t             tag_wr;
	logic [l1_cache_pkg::BLOCK_W-1:0]     data_rd;
	logic [l1_cache_pkg::BLOCK_W-1:0]     data_wr;
	logic [l1_cache_pkg::BLOCK_W-1:0]     merged_blk;
	logic [l1_cache_pkg::TAG_W-1:0]       ext_tag;

	logic [l1_cache_pkg::NUM_LINES-1:0]   valid_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// valid bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (valid_set) begin
			valid_q[req_index] <= 1'b1; // set on refill, never cleared again
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// store outputs belong to the index read in idle
	assign hit   = valid_q[req_index] && (tag_rd.tag == req_tag);
	assign dirty = valid_q[req_index] && tag_rd.dirty;

	// word k sits at bits 32k+31..32k
	assign rdata_o = data_rd[l1_cache_pkg::DATA_W*req_word +: l1_cache_pkg::DATA_W];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line update
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		merged_blk = data_rd;
		merged_blk[l1_cache_pkg::DATA_W*req_word +: l1_cache_pkg::DATA_W] = req_i.wdata;
	end

	assign data_wr = fill ? ext_rdata_i : merged_blk;

	// refill leaves the line clean, a write hit marks it dirty
	always_comb begin
		tag_wr.dirty = ~fill;
		tag_wr.tag   = req_tag;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// external request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign ext_tag = victim ? tag_rd.tag : req_tag; // victim tag on writeback

	always_comb begin
		ext_mreq_o.addr  = {ext_tag, req_index, {l1_cache_pkg::OFFSET_W{1'b0}}};
		ext_mreq_o.wdata = data_rd; // stored block, steady while the stores are idle
		ext_mreq_o.we    = ext_we;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// controller and stores
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	l1_cache_controller u_ctrl (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.cs_i        (cs_i),
		.we_i        (req_i.we),
		.hit_i       (hit),
		.dirty_i     (dirty),
		.ext_ack_i   (ext_ack_i),
		.sram_cs_o   (sram_cs),
		.line_we_o   (line_we),
		.fill_o      (fill),
		.victim_o    (victim),
		.valid_set_o (valid_set),
		.ext_req_o   (ext_req_o),
		.ext_we_o    (ext_we),
		.stall_o     (stall_o)
	);

	// dirty bit and tag per line
	sram #(
		.addr_width (l1_cache_pkg::INDEX_W),
		.data_width ($bits(l1_cache_pkg::tag_entry_t))
	) u_tag_mem (
		.clk    (clk),
		.cs_i   (sram_cs),
		.we_i   (line_we),
		.addr_i (req_index),
		.data_i (tag_wr),
		.data_o (tag_rd)
	);

	// one block per line
	sram #(
		.addr_width (l1_cache_pkg::INDEX_W),
		.data_width (l1_cache_pkg::BLOCK_W)
	) u_data_mem (
		.clk    (clk),
		.cs_i   (sram_cs),
		.we_i   (line_we),
		.addr_i (req_index),
		.data_i (data_wr),
		.data_o (data_rd)
	);

endmodule

`default_nettype wire

// File: verilog/l1_cache_controller.sv
`default_nettype none

module l1_cache_controller (
	input  wire  clk,
	input  wire  rst_n_i,
	input  wire  cs_i,        // processor chip select
	input  wire  we_i,        // processor write
	input  wire  hit_i,
	input  wire  dirty_i,
	input  wire  ext_ack_i,
	output logic sram_cs_o,   // tag and data store select
	output logic line_we_o,   // write tag and data store
	output logic fill_o,      // refill block instead of merged block
	output logic victim_o,    // stored tag forms the external address
	output logic valid_set_o,
	output logic ext_req_o,
	output logic ext_we_o,
	output logic stall_o
);

	l1_cache_pkg::ctrl_state_t state_q;
	l1_cache_pkg::ctrl_state_t state_d;

	logic in_idle;
	logic in_lookup;
	logic write_hit;
	logic fill_done;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= l1_cache_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			l1_cache_pkg::IDLE: begin
				if (cs_i) begin
					state_d = l1_cache_pkg::LOOKUP; // store read issued this cycle
				end
			end
			l1_cache_pkg::LOOKUP: begin
				if (!cs_i || hit_i) begin
					state_d = l1_cache_pkg::IDLE;
				end else if (dirty_i) begin
					state_d = l1_cache_pkg::WB_REQ;
				end else begin
					state_d = l1_cache_pkg::FILL_REQ;
				end
			end
			l1_cache_pkg::WB_REQ: begin
				if (ext_ack_i) begin
					state_d = l1_cache_pkg::WB_RELEASE;
				end
			end
			l1_cache_pkg::WB_RELEASE: begin
				// memory must drop ack before the refill request
				if (!ext_ack_i) begin
					state_d = l1_cache_pkg::FILL_REQ;
				end
			end
			l1_cache_pkg::FILL_REQ: begin
				if (ext_ack_i) begin
					state_d = l1_cache_pkg::FILL_RELEASE;
				end
			end
			l1_cache_pkg::FILL_RELEASE: begin
				if (!ext_ack_i) begin
					state_d = l1_cache_pkg::IDLE; // lookup runs again, now a hit
				end
			end
			default: begin
				state_d = l1_cache_pkg::IDLE;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign in_idle   = (state_q == l1_cache_pkg::IDLE);
	assign in_lookup = (state_q == l1_cache_pkg::LOOKUP);

	// write hit updates the line in the completing cycle
	assign write_hit = in_lookup && cs_i && hit_i && we_i;

	// refill data is valid while ack is high
	assign fill_done = (state_q == l1_cache_pkg::FILL_REQ) && ext_ack_i;

	assign line_we_o   = write_hit || fill_done;
	assign sram_cs_o   = (in_idle && cs_i) || line_we_o; // read in idle, else write
	assign fill_o      = (state_q == l1_cache_pkg::FILL_REQ);
	assign valid_set_o = fill_done;

	assign victim_o  = (state_q == l1_cache_pkg::WB_REQ);
	assign ext_we_o  = (state_q == l1_cache_pkg::WB_REQ);
	assign ext_req_o = (state_q == l1_cache_pkg::WB_REQ) ||
	                   (state_q == l1_cache_pkg::FILL_REQ);

	// only a hit in lookup lets the access finish
	assign stall_o = cs_i && !(in_lookup && hit_i);

endmodule

`default_nettype wire

// File: verilog/sram.sv
`default_nettype none

// single port, one write or read per cycle
module sram #(
	parameter int addr_width = 5,
	parameter int data_width = 32
) (
	input  wire                   clk,
	input  wire                   cs_i,
	input  wire                   we_i,
	input  wire  [addr_width-1:0] addr_i,
	input  wire  [data_width-1:0] data_i,
	output logic [data_width-1:0] data_o
);

	logic [data_width-1:0] mem [0:(2**addr_width)-1];
	logic [addr_width-1:0] addr_q; // registered read address

	always_ff @(posedge clk) begin
		if (cs_i) begin
			addr_q <= addr_i;
			if (we_i) begin
				mem[addr_i] <= data_i;
			end
		end
	end

	// read data follows the address latched on the last selected edge
	assign data_o = mem[addr_q];

endmodule

`default_nettype wire

// File: verilog/l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_W     = 32;  // byte address
	localparam int DATA_W     = 32;  // processor word
	localparam int TAG_W      = 22;
	localparam int INDEX_W    = 5;
	localparam int OFFSET_W   = 5;   // byte offset inside a block
	localparam int WORD_SEL_W = 3;   // offset bits 4..2
	localparam int NUM_LINES  = 32;
	localparam int BLOCK_W    = 256; // eight words per line

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// processor request, held steady until stall drops
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              we;
	} cpu_req_t;

	// block request toward external memory
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;  // block aligned, low offset bits zero
		logic [BLOCK_W-1:0] wdata; // victim block on writeback
		logic               we;    // 1 = writeback, 0 = refill
	} mem_req_t;

	// one entry of the tag store
	typedef struct packed {
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// controller states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		IDLE         = 3'd0, // waiting for chip select, start sram read
		LOOKUP       = 3'd1, // tag compare on sram output
		WB_REQ       = 3'd2, // victim block out, wait for ack
		WB_RELEASE   = 3'd3, // req low, wait for ack low
		FILL_REQ     = 3'd4, // refill read, write line on ack
		FILL_RELEASE = 3'd5  // req low, wait for ack low
	} ctrl_state_t;

endpackage

`default_nettype wire
